/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_core_io -Mdir obj_dir

run: compile
	./obj_dir/Vtb_core_io 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "No pass message found"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/core_io_pkg.sv */
`default_nettype none

package core_io_pkg;

  localparam int WORD_W = 32;
  localparam int DESC_W = 64;
  localparam int TAG_W  = 5;
  localparam int OFFS_W = 7;

  // Same 7-bit offset seen as word registers or as 64-bit registers
  typedef union packed {
    struct packed {
      logic [4:0] idx;
      logic [1:0] lane;
    } word;
    struct packed {
      logic [3:0] idx;
      logic       half;
      logic [1:0] lane;
    } dword;
  } io_offset_u;

  typedef enum logic [3:0] {
    KIND_DESC_WR,
    KIND_FLAGS_WR,
    KIND_STEP_WR,
    KIND_SEND,
    KIND_TAKE,
    KIND_FLAG_CLR,
    KIND_MASK_WR,
    KIND_ACK,
    KIND_RD_DESC,
    KIND_RD_FLAGS,
    KIND_RD_STAT,
    KIND_RD_ID,
    KIND_RD_TIMER_L,
    KIND_RD_TIMER_H,
    KIND_RD_IRQ,
    KIND_NONE
  } io_kind_e;

  //////////////////////////////////////////
  // Write side at offsets 0x00 to 0x3F
  localparam logic [OFFS_W-1:0] OFFS_SEND_DESC  = 7'h00;
  localparam logic [OFFS_W-1:0] OFFS_TIMER_STEP = 7'h14;
  localparam logic [OFFS_W-1:0] OFFS_DRAM_FLAGS = 7'h18;
  localparam logic [OFFS_W-1:0] OFFS_SEND_STRB  = 7'h38;
  localparam logic [OFFS_W-1:0] OFFS_TAKE_STRB  = 7'h39;
  localparam logic [OFFS_W-1:0] OFFS_FLAG_CLR   = 7'h3A;
  localparam logic [OFFS_W-1:0] OFFS_MASK_WR    = 7'h3C;
  localparam logic [OFFS_W-1:0] OFFS_IRQ_ACK    = 7'h3D;

  //////////////////////////////////////////
  // Read side at offsets 0x40 and up
  localparam logic [OFFS_W-1:0] OFFS_RD_DESC    = 7'h40;
  localparam logic [OFFS_W-1:0] OFFS_RD_FLAGS   = 7'h48;
  localparam logic [OFFS_W-1:0] OFFS_RD_STAT    = 7'h4C;
  localparam logic [OFFS_W-1:0] OFFS_RD_ID      = 7'h50;
  localparam logic [OFFS_W-1:0] OFFS_RD_TIMER_L = 7'h54;
  localparam logic [OFFS_W-1:0] OFFS_RD_TIMER_H = 7'h58;
  localparam logic [OFFS_W-1:0] OFFS_RD_IRQ     = 7'h5C;

  // Timer, DRAM and descriptor interrupts start blocked
  localparam logic [7:0]        MASK_RESET = 8'h1F;
  localparam logic [WORD_W-1:0] STEP_RESET = 1;

  localparam int MASK_BIT_TIMER = 5;
  localparam int MASK_BIT_DRAM  = 6;
  localparam int MASK_BIT_DESC  = 7;
  localparam int ACK_BIT_TIMER  = 5;

endpackage

`default_nettype wire

/* hdl/core_io_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_io_top #(
  parameter int CORE_ID_WIDTH = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [CORE_ID_WIDTH-1:0]       core_id,

  // Core data bus in the I/O window
  input  logic                           cmd_valid,
  output logic                           cmd_ready,
  input  logic                           cmd_write,
  input  logic [core_io_pkg::OFFS_W-1:0] cmd_addr,
  input  logic [1:0]                     cmd_size,
  input  logic [core_io_pkg::WORD_W-1:0] cmd_wdata,
  output logic                           rsp_valid,
  output logic [core_io_pkg::WORD_W-1:0] rsp_data,

  output logic [core_io_pkg::DESC_W-1:0] data_desc,
  output logic                           data_desc_valid,
  input  logic                           data_desc_ready,

  input  logic [core_io_pkg::DESC_W-1:0] in_desc,
  input  logic                           in_desc_valid,
  output logic                           in_desc_taken,

  input  logic [core_io_pkg::TAG_W-1:0]  recv_dram_tag,
  input  logic                           recv_dram_tag_valid,

  output logic                           timer_irq,
  output logic                           ext_irq
);

  io_cmd_if cmd_if ();

  io_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_size  (cmd_size),
    .cmd_wdata (cmd_wdata),
    .cmd_ready (cmd_ready),
    .cmd       (cmd_if)
  );

  io_exec #(
    .CORE_ID_WIDTH (CORE_ID_WIDTH)
  ) u_exec (
    .clk                 (clk),
    .rst                 (rst),
    .cmd                 (cmd_if),
    .core_id             (core_id),
    .in_desc             (in_desc),
    .in_desc_valid       (in_desc_valid),
    .in_desc_taken       (in_desc_taken),
    .data_desc           (data_desc),
    .data_desc_valid     (data_desc_valid),
    .data_desc_ready     (data_desc_ready),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .rsp_valid           (rsp_valid),
    .rsp_data            (rsp_data),
    .timer_irq           (timer_irq),
    .ext_irq             (ext_irq)
  );

endmodule

`default_nettype wire

/* hdl/dram_recv_flags.sv */
`timescale 1ns/10ps
`default_nettype none

module dram_recv_flags (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [core_io_pkg::TAG_W-1:0]    tag,
  input  logic                             tag_valid,
  input  logic                             wr_en,
  input  logic [core_io_pkg::WORD_W/8-1:0] byte_mask,
  input  logic [core_io_pkg::WORD_W-1:0]   wdata,
  input  logic                             clr_en,
  input  logic [core_io_pkg::TAG_W-1:0]    clr_tag,
  output logic [core_io_pkg::WORD_W-1:0]   flags,
  output logic                             any
);

  logic [core_io_pkg::TAG_W-1:0]  tag_r;
  logic                           tag_valid_r;
  logic [core_io_pkg::WORD_W-1:0] flags_next;

  // Arriving tags pass one register stage
  always_ff @(posedge clk) begin
    tag_r <= tag;
    if (rst)
      tag_valid_r <= 1'b0;
    else
      tag_valid_r <= tag_valid;
  end

  // Later assignments win, so an arriving tag beats a clear
  always_comb begin
    flags_next = flags;
    if (wr_en) begin
      for (int i = 0; i < core_io_pkg::WORD_W/8; i++) begin
        if (byte_mask[i])
          flags_next[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    if (clr_en)
      flags_next[clr_tag] = 1'b0;
    if (tag_valid_r)
      flags_next[tag_r] = 1'b1;
    flags_next[0] = 1'b0;   // tag 0 is never a valid slot
  end

  always_ff @(posedge clk) begin
    if (rst)
      flags <= '0;
    else
      flags <= flags_next;
  end

  assign any = |flags;

endmodule

`default_nettype wire

/* hdl/event_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module event_timer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             step_wr,
  input  logic [core_io_pkg::WORD_W/8-1:0] byte_mask,
  input  logic [core_io_pkg::WORD_W-1:0]   wdata,
  input  logic                             ack,
  output logic [63:0]                      now,
  output logic                             irq
);

  logic [core_io_pkg::WORD_W-1:0] step_r;
  logic [core_io_pkg::WORD_W-1:0] interval;

  always_ff @(posedge clk) begin
    if (rst)
      now <= '0;
    else
      now <= now + 64'd1;
  end

  // Nonzero reset step keeps the interval well defined
  always_ff @(posedge clk) begin
    if (rst) begin
      step_r <= core_io_pkg::STEP_RESET;
    end else if (step_wr) begin
      for (int i = 0; i < core_io_pkg::WORD_W/8; i++) begin
        if (byte_mask[i])
          step_r[i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // Interval restarts on reset, on a step write and on every expiry
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      interval <= '0;
      irq      <= 1'b0;
    end else if (interval == step_r) begin
      interval <= '0;
      irq      <= 1'b1;
    end else begin
      interval <= interval + 1'b1;
      if (ack)
        irq <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/io_cmd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface io_cmd_if;

  logic                           valid;
  logic                           ready;
  core_io_pkg::io_kind_e          kind;
  core_io_pkg::io_offset_u        offs;
  logic [3:0]                     byte_mask;
  logic [core_io_pkg::WORD_W-1:0] wdata;
  // Byte taken from the addressed lane for all strobes
  logic [7:0]                     sbyte;

  modport decode (
    output valid, kind, offs, byte_mask, wdata, sbyte,
    input  ready
  );

  modport exec (
    input  valid, kind, offs, byte_mask, wdata, sbyte,
    output ready
  );

endinterface

`default_nettype wire

/* hdl/io_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module io_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_valid,
  input  logic                           cmd_write,
  input  logic [core_io_pkg::OFFS_W-1:0] cmd_addr,
  input  logic [1:0]                     cmd_size,
  input  logic [core_io_pkg::WORD_W-1:0] cmd_wdata,
  output logic                           cmd_ready,
  io_cmd_if.decode                       cmd
);

  core_io_pkg::io_offset_u offs;
  core_io_pkg::io_kind_e   kind;
  logic [6:0]              word_offs;
  logic [3:0]              byte_mask;
  logic [7:0]              sbyte;
  logic                    ready_en;
  logic                    accept;

  assign offs      = cmd_addr;
  assign word_offs = {offs.word.idx, offs.word.lane};

  // 64-bit registers through the dword view, the rest through the word view
  always_comb begin
    kind = core_io_pkg::KIND_NONE;
    if (cmd_write) begin
      if (offs.dword.idx == core_io_pkg::OFFS_SEND_DESC[6:3])
        kind = core_io_pkg::KIND_DESC_WR;
      else if (offs.word.idx == core_io_pkg::OFFS_TIMER_STEP[6:2])
        kind = core_io_pkg::KIND_STEP_WR;
      else if (offs.word.idx == core_io_pkg::OFFS_DRAM_FLAGS[6:2])
        kind = core_io_pkg::KIND_FLAGS_WR;
      else if (word_offs == core_io_pkg::OFFS_SEND_STRB)
        kind = core_io_pkg::KIND_SEND;
      else if (word_offs == core_io_pkg::OFFS_TAKE_STRB)
        kind = core_io_pkg::KIND_TAKE;
      else if (word_offs == core_io_pkg::OFFS_FLAG_CLR)
        kind = core_io_pkg::KIND_FLAG_CLR;
      else if (word_offs == core_io_pkg::OFFS_MASK_WR)
        kind = core_io_pkg::KIND_MASK_WR;
      else if (word_offs == core_io_pkg::OFFS_IRQ_ACK)
        kind = core_io_pkg::KIND_ACK;
    end else begin
      if (offs.dword.idx == core_io_pkg::OFFS_RD_DESC[6:3])
        kind = core_io_pkg::KIND_RD_DESC;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_FLAGS[6:2])
        kind = core_io_pkg::KIND_RD_FLAGS;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_STAT[6:2])
        kind = core_io_pkg::KIND_RD_STAT;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_ID[6:2])
        kind = core_io_pkg::KIND_RD_ID;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_TIMER_L[6:2])
        kind = core_io_pkg::KIND_RD_TIMER_L;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_TIMER_H[6:2])
        kind = core_io_pkg::KIND_RD_TIMER_H;
      else if (offs.word.idx == core_io_pkg::OFFS_RD_IRQ[6:2])
        kind = core_io_pkg::KIND_RD_IRQ;
    end
  end

  // Size 0 is a byte, 1 a halfword, anything else a full word
  always_comb begin
    case (cmd_size)
      2'd0:    byte_mask = 4'b0001 << offs.word.lane;
      2'd1:    byte_mask = 4'b0011 << offs.word.lane;
      default: byte_mask = 4'b1111;
    endcase
  end

  assign sbyte = cmd_wdata[{offs.word.lane, 3'b000} +: 8];

  //////////////////////////////////////////
  // One-entry stage
  assign cmd_ready = ready_en && (!cmd.valid || cmd.ready);
  assign accept    = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_en  <= 1'b0;
      cmd.valid <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (accept)
        cmd.valid <= 1'b1;
      else if (cmd.ready)
        cmd.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.kind      <= kind;
      cmd.offs      <= offs;
      cmd.byte_mask <= byte_mask;
      cmd.wdata     <= cmd_wdata;
      cmd.sbyte     <= sbyte;
    end
  end

endmodule

`default_nettype wire

/* hdl/io_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module io_exec #(
  parameter int CORE_ID_WIDTH = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  io_cmd_if.exec                         cmd,
  input  logic [CORE_ID_WIDTH-1:0]       core_id,
  input  logic [core_io_pkg::DESC_W-1:0] in_desc,
  input  logic                           in_desc_valid,
  output logic                           in_desc_taken,
  output logic [core_io_pkg::DESC_W-1:0] data_desc,
  output logic                           data_desc_valid,
  input  logic                           data_desc_ready,
  input  logic [core_io_pkg::TAG_W-1:0]  recv_dram_tag,
  input  logic                           recv_dram_tag_valid,
  output logic                           rsp_valid,
  output logic [core_io_pkg::WORD_W-1:0] rsp_data,
  output logic                           timer_irq,
  output logic                           ext_irq
);

  logic                           xfer;
  logic                           strobe_bit;
  logic [7:0]                     desc_mask;
  logic [7:0]                     mask_r;
  logic [core_io_pkg::WORD_W-1:0] flags;
  logic [core_io_pkg::WORD_W-1:0] rd_data;
  logic [63:0]                    now;
  logic                           flags_any;
  logic                           timer_raw;
  logic                           flags_wr;
  logic                           flag_clr;
  logic                           step_wr;
  logic                           timer_ack;

  assign strobe_bit = cmd.sbyte[0];

  // A second send waits until the pending descriptor leaves
  assign cmd.ready = !((cmd.kind == core_io_pkg::KIND_SEND) && strobe_bit && data_desc_valid);
  assign xfer      = cmd.valid && cmd.ready;

  assign flags_wr  = xfer && (cmd.kind == core_io_pkg::KIND_FLAGS_WR);
  assign flag_clr  = xfer && (cmd.kind == core_io_pkg::KIND_FLAG_CLR);
  assign step_wr   = xfer && (cmd.kind == core_io_pkg::KIND_STEP_WR);
  assign timer_ack = xfer && (cmd.kind == core_io_pkg::KIND_ACK)
                     && cmd.sbyte[core_io_pkg::ACK_BIT_TIMER];

  //////////////////////////////////////////
  // Outgoing descriptor
  assign desc_mask = {4'b0000, cmd.byte_mask} << {cmd.offs.dword.half, 2'b00};

  always_ff @(posedge clk) begin
    if (xfer && (cmd.kind == core_io_pkg::KIND_DESC_WR)) begin
      for (int i = 0; i < 8; i++) begin
        if (desc_mask[i])
          data_desc[i*8 +: 8] <= cmd.wdata[(i%4)*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mask_r          <= core_io_pkg::MASK_RESET;
      data_desc_valid <= 1'b0;
      in_desc_taken   <= 1'b0;
      rsp_valid       <= 1'b0;
    end else begin
      rsp_valid     <= xfer;
      in_desc_taken <= xfer && (cmd.kind == core_io_pkg::KIND_TAKE) && strobe_bit;
      if (xfer && (cmd.kind == core_io_pkg::KIND_MASK_WR))
        mask_r <= cmd.sbyte;
      if (xfer && (cmd.kind == core_io_pkg::KIND_SEND) && strobe_bit)
        data_desc_valid <= 1'b1;
      else if (data_desc_ready)
        data_desc_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////
  // Read data is zero for writes and holes
  always_comb begin
    rd_data = '0;
    case (cmd.kind)
      core_io_pkg::KIND_RD_DESC:
        rd_data = cmd.offs.dword.half ? in_desc[63:32] : in_desc[31:0];
      core_io_pkg::KIND_RD_FLAGS:
        rd_data = flags;
      core_io_pkg::KIND_RD_STAT: begin
        rd_data[0] = in_desc_valid;
        rd_data[8] = data_desc_ready;
      end
      core_io_pkg::KIND_RD_ID:
        rd_data[CORE_ID_WIDTH-1:0] = core_id;
      core_io_pkg::KIND_RD_TIMER_L:
        rd_data = now[31:0];
      core_io_pkg::KIND_RD_TIMER_H:
        rd_data = now[63:32];
      core_io_pkg::KIND_RD_IRQ: begin
        rd_data[15:8]                       = mask_r;
        rd_data[core_io_pkg::MASK_BIT_DESC]  = in_desc_valid;
        rd_data[core_io_pkg::MASK_BIT_DRAM]  = flags_any;
        rd_data[core_io_pkg::MASK_BIT_TIMER] = timer_raw;
      end
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (xfer)
      rsp_data <= rd_data;
  end

  dram_recv_flags u_flags (
    .clk       (clk),
    .rst       (rst),
    .tag       (recv_dram_tag),
    .tag_valid (recv_dram_tag_valid),
    .wr_en     (flags_wr),
    .byte_mask (cmd.byte_mask),
    .wdata     (cmd.wdata),
    .clr_en    (flag_clr),
    .clr_tag   (cmd.sbyte[core_io_pkg::TAG_W-1:0]),
    .flags     (flags),
    .any       (flags_any)
  );

  event_timer u_timer (
    .clk       (clk),
    .rst       (rst),
    .step_wr   (step_wr),
    .byte_mask (cmd.byte_mask),
    .wdata     (cmd.wdata),
    .ack       (timer_ack),
    .now       (now),
    .irq       (timer_raw)
  );

  assign timer_irq = timer_raw && mask_r[core_io_pkg::MASK_BIT_TIMER];
  assign ext_irq   = (flags_any && mask_r[core_io_pkg::MASK_BIT_DRAM])
                     || (in_desc_valid && mask_r[core_io_pkg::MASK_BIT_DESC]);

endmodule

`default_nettype wire

/* sim/core_io_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module core_io_asserts (
  input wire        clk,
  input wire        rst,
  input wire [63:0] data_desc,
  input wire        data_desc_valid,
  input wire        data_desc_ready,
  input wire        rsp_valid,
  input wire        in_desc_taken
);

  // Pending descriptor must not change before it is taken
  desc_stable: assert property (@(posedge clk) disable iff (rst)
    data_desc_valid && !data_desc_ready |=> data_desc_valid && $stable(data_desc))
    else $error("data_desc changed while waiting for ready");

  rsp_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !rsp_valid)
    else $error("rsp_valid high during reset");

  taken_pulse: assert property (@(posedge clk) disable iff (rst)
    in_desc_taken |=> !in_desc_taken)
    else $error("in_desc_taken longer than one cycle");

endmodule

bind core_io_top core_io_asserts u_asserts (
  .clk             (clk),
  .rst             (rst),
  .data_desc       (data_desc),
  .data_desc_valid (data_desc_valid),
  .data_desc_ready (data_desc_ready),
  .rsp_valid       (rsp_valid),
  .in_desc_taken   (in_desc_taken)
);

`default_nettype wire

/* sim/tb_core_io.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core_io;

  logic                           clk;
  logic                           rst;
  logic [3:0]                     core_id;
  logic                           cmd_valid;
  logic                           cmd_ready;
  logic                           cmd_write;
  logic [core_io_pkg::OFFS_W-1:0] cmd_addr;
  logic [1:0]                     cmd_size;
  logic [core_io_pkg::WORD_W-1:0] cmd_wdata;
  logic                           rsp_valid;
  logic [core_io_pkg::WORD_W-1:0] rsp_data;
  logic [core_io_pkg::DESC_W-1:0] data_desc;
  logic                           data_desc_valid;
  logic                           data_desc_ready;
  logic [core_io_pkg::DESC_W-1:0] in_desc;
  logic                           in_desc_valid;
  logic                           in_desc_taken;
  logic [core_io_pkg::TAG_W-1:0]  recv_dram_tag;
  logic                           recv_dram_tag_valid;
  logic                           timer_irq;
  logic                           ext_irq;

  logic [31:0] lfsr_state = 32'ha436_8264;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          cmd_count = 0;
  int          rsp_count = 0;
  int          desc_count = 0;
  int          take_count = 0;
  int          cycle = 0;

  core_io_top #(.CORE_ID_WIDTH(4)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Event counters sampled at the clock edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rsp_valid)
      rsp_count <= rsp_count + 1;
    if (data_desc_valid && data_desc_ready)
      desc_count <= desc_count + 1;
    if (in_desc_taken)
      take_count <= take_count + 1;
  end

  ////////////////////////////////////////
  // Helpers
  function automatic logic [31:0] get_rand(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      // Galois step for x^32 + x^22 + x^2 + x + 1
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $finish;
  endtask

  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string msg, input logic [core_io_pkg::WORD_W-1:0] got,
                            input logic [core_io_pkg::WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_desc(input string msg, input logic [core_io_pkg::DESC_W-1:0] got,
                            input logic [core_io_pkg::DESC_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic issue_cmd(input logic wr, input logic [6:0] addr, input logic [1:0] size,
                           input logic [31:0] wdata);
    int n;
    n = 0;
    cmd_valid = 1'b1;
    cmd_write = wr;
    cmd_addr  = addr;
    cmd_size  = size;
    cmd_wdata = wdata;
    while (!cmd_ready) begin
      step_cycles(1);
      n++;
      if (n > 100)
        abort_run("Timeout: cmd_ready never rose");
    end
    step_cycles(1);
    cmd_valid = 1'b0;
    cmd_count++;
  endtask

  task automatic wait_rsp(output logic [31:0] data);
    int n;
    n = 0;
    while (!rsp_valid) begin
      step_cycles(1);
      n++;
      if (n > 100)
        abort_run("Timeout: no response to a command");
    end
    data = rsp_data;
    step_cycles(1);
  endtask

  task automatic bus_write(input logic [6:0] addr, input logic [1:0] size,
                           input logic [31:0] wdata);
    logic [31:0] d;
    issue_cmd(1'b1, addr, size, wdata);
    wait_rsp(d);
    check_word("write response data", d, 32'h0);
  endtask

  task automatic bus_read(input logic [6:0] addr, output logic [31:0] data);
    issue_cmd(1'b0, addr, 2'd2, 32'h0);
    wait_rsp(data);
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: FAILED with %0d errors", name, errors - test_errors);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////
  // Tests
  task automatic test_identity();
    logic [31:0] d;
    begin_test();
    bus_read(7'h5C, d);
    check_word("mask after reset", {24'h0, d[15:8]}, 32'h1F);
    bus_read(7'h50, d);
    check_word("core id", d, 32'hA);
    bus_read(7'h60, d);
    check_word("unmapped 0x60", d, 32'h0);
    bus_read(7'h7C, d);
    check_word("unmapped 0x7C", d, 32'h0);
    bus_read(7'h10, d);
    check_word("unmapped 0x10", d, 32'h0);
    bus_write(7'h30, 2'd2, 32'hDEAD_BEEF);
    report_test("identity_mask_unmapped");
  endtask

  task automatic test_desc_send();
    logic [63:0] exp;
    logic [31:0] r;
    logic [31:0] d;
    logic [6:0]  a;
    logic [1:0]  sz;
    int          n;
    int          base;
    begin_test();
    exp = '0;
    r = get_rand(32);
    bus_write(7'h00, 2'd2, r);
    exp[31:0] = r;
    r = get_rand(32);
    bus_write(7'h04, 2'd2, r);
    exp[63:32] = r;
    for (int k = 0; k < 6; k++) begin
      d = get_rand(1);
      sz = {1'b0, d[0]};
      d = get_rand(3);
      a = {4'h0, d[2:0]};
      if (sz == 2'd1)
        a[0] = 1'b0;
      r = get_rand(32);
      bus_write(a, sz, r);
      for (int l = 0; l < 4; l++) begin
        if ((sz == 2'd0 && l == a[1:0]) || (sz == 2'd1 && (l == a[1:0] || l == a[1:0] + 1)))
          exp[(a[2]*4 + l)*8 +: 8] = r[l*8 +: 8];
      end
    end
    base = desc_count;
    bus_write(7'h38, 2'd0, 32'h01);
    n = 0;
    while (!data_desc_valid) begin
      step_cycles(1);
      n++;
      if (n > 50)
        abort_run("Timeout: data_desc_valid never rose");
    end
    check_desc("descriptor after send", data_desc, exp);
    step_cycles(5);
    check_desc("descriptor held under back-pressure", data_desc, exp);
    // Second send stalls behind the pending one
    issue_cmd(1'b1, 7'h38, 2'd0, 32'h01);
    n = rsp_count;
    step_cycles(4);
    check_word("cmd_ready while stalled", {31'h0, cmd_ready}, 32'h0);
    check_word("responses while stalled", n, rsp_count);
    data_desc_ready = 1'b1;
    wait_rsp(d);
    check_word("second send response data", d, 32'h0);
    n = 0;
    while (data_desc_valid) begin
      step_cycles(1);
      n++;
      if (n > 50)
        abort_run("Timeout: second descriptor never accepted");
    end
    data_desc_ready = 1'b0;
    step_cycles(2);
    check_word("descriptors accepted", desc_count - base, 32'd2);
    check_desc("descriptor after sends", data_desc, exp);
    report_test("desc_send");
  endtask

  task automatic test_incoming();
    logic [31:0] d;
    logic [31:0] r;
    int          base;
    begin_test();
    r = get_rand(32);
    in_desc[31:0] = r;
    r = get_rand(32);
    in_desc[63:32] = r;
    in_desc_valid = 1'b1;
    bus_read(7'h40, d);
    check_word("in_desc low", d, in_desc[31:0]);
    bus_read(7'h44, d);
    check_word("in_desc high", d, in_desc[63:32]);
    base = take_count;
    bus_write(7'h39, 2'd0, 32'h0000_0100);
    step_cycles(2);
    check_word("take pulses", take_count - base, 32'd1);
    bus_write(7'h39, 2'd0, 32'h0000_FE00);
    step_cycles(2);
    check_word("take pulses with bit 0 clear", take_count - base, 32'd1);
    bus_read(7'h4C, d);
    check_word("status", d, 32'h0000_0001);
    data_desc_ready = 1'b1;
    bus_read(7'h4C, d);
    check_word("status with ready", d, 32'h0000_0101);
    data_desc_ready = 1'b0;
    in_desc_valid = 1'b0;
    report_test("incoming_desc");
  endtask

  task automatic apply_tag(input logic [4:0] t);
    recv_dram_tag       = t;
    recv_dram_tag_valid = 1'b1;
    step_cycles(1);
    recv_dram_tag_valid = 1'b0;
  endtask

  task automatic test_flags();
    logic [31:0] d;
    begin_test();
    apply_tag(5'd3);
    apply_tag(5'd17);
    apply_tag(5'd0);
    step_cycles(2);
    bus_read(7'h48, d);
    check_word("flags after tags", d, 32'h0002_0008);
    bus_write(7'h3A, 2'd0, 32'h0003_0000);
    bus_read(7'h48, d);
    check_word("flags after clear", d, 32'h0002_0000);
    bus_write(7'h19, 2'd0, 32'h0000_A000);
    bus_read(7'h48, d);
    check_word("flags after byte write", d, 32'h0002_A000);
    check_word("ext_irq with bit 6 clear", {31'h0, ext_irq}, 32'h0);
    bus_write(7'h3C, 2'd0, 32'h40);
    check_word("ext_irq with bit 6 set", {31'h0, ext_irq}, 32'h1);
    bus_write(7'h3C, 2'd0, 32'h1F);
    report_test("dram_flags");
  endtask

  task automatic test_timer();
    logic [31:0] t1;
    logic [31:0] t2;
    int          c1;
    int          c2;
    int          n;
    begin_test();
    bus_read(7'h54, t1);
    c1 = cycle;
    step_cycles(7);
    bus_read(7'h54, t2);
    c2 = cycle;
    if (t2 - t1 < c2 - c1) begin
      $display("Mismatch at %0t: timer advanced %0d in %0d cycles", $time, t2 - t1, c2 - c1);
      errors++;
    end
    bus_write(7'h3C, 2'd0, 32'h20);
    bus_write(7'h14, 2'd2, 32'd20);
    for (int k = 0; k < 20; k++) begin
      check_word("timer_irq before the interval ends", {31'h0, timer_irq}, 32'h0);
      step_cycles(1);
    end
    n = 0;
    while (!timer_irq) begin
      step_cycles(1);
      n++;
      if (n > 50)
        abort_run("Timeout: timer_irq never rose");
    end
    bus_write(7'h3C, 2'd0, 32'h00);
    check_word("timer_irq masked", {31'h0, timer_irq}, 32'h0);
    bus_write(7'h3C, 2'd0, 32'h20);
    check_word("timer_irq unmasked", {31'h0, timer_irq}, 32'h1);
    bus_write(7'h3D, 2'd0, 32'h0000_2000);
    check_word("timer_irq after ack", {31'h0, timer_irq}, 32'h0);
    bus_write(7'h14, 2'd2, 32'h0010_0000);
    bus_write(7'h3C, 2'd0, 32'h1F);
    report_test("timer");
  endtask

  initial begin
    rst                 = 1'b1;
    core_id             = 4'hA;
    cmd_valid           = 1'b0;
    cmd_write           = 1'b0;
    cmd_addr            = '0;
    cmd_size            = '0;
    cmd_wdata           = '0;
    data_desc_ready     = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    test_identity();
    test_desc_send();
    test_incoming();
    test_flags();
    test_timer();
    step_cycles(3);
    check_word("one response per command", rsp_count, cmd_count);
    $display("Tests: %0d passed, %0d failed, %0d check errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/core_io_pkg.sv
hdl/io_cmd_if.sv
hdl/io_decode.sv
hdl/dram_recv_flags.sv
hdl/event_timer.sv
hdl/io_exec.sv
hdl/core_io_top.sv
sim/core_io_asserts.sv
sim/tb_core_io.sv
